// ==== Bender.yml ====
package:
  name: lsu_op_manager

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_sequencer.sv
      - hdl/lsu_lane_buffer.sv
      - hdl/lsu_wb_master.sv
      - hdl/lsu_op_manager.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/lsu_op_manager_assert.sv
      - dv/lsu_op_manager_tb.sv

// ==== dv/lsu_op_manager_assert.sv ====
`default_nettype none

module lsu_op_manager_assert (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  lsu_pkg::vgpr_rd_t  vgpr_rd,
    input  lsu_pkg::vgpr_wr_t  vgpr_wr,
    input  lsu_pkg::wb_req_t   wb,
    input  lsu_pkg::wb_rsp_t   wb_in,
    input  lsu_pkg::lsu_done_t done
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_errors = 0;

    stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb.stb |-> wb.cyc)
        else begin
            assert_errors++;
            $error("stb high outside a bus cycle");
        end

    // Classic cycle holds the request until ack
    req_stable: assert property (@(posedge clk) disable iff (rst)
        wb.stb && !wb_in.ack |=> $stable(wb.adr) && $stable(wb.we) && $stable(wb.dat_w))
        else begin
            assert_errors++;
            $error("bus request changed before ack");
        end

    rf_one_port: assert property (@(posedge clk) disable iff (rst) !(vgpr_rd.en && vgpr_wr.en))
        else begin
            assert_errors++;
            $error("register read and write in the same cycle");
        end

    rdy_not_done: assert property (@(posedge clk) disable iff (rst) !(rdy && done.valid))
        else begin
            assert_errors++;
            $error("rdy high during completion");
        end

endmodule

bind lsu_op_manager lsu_op_manager_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .rdy     (rdy),
    .vgpr_rd (vgpr_rd),
    .vgpr_wr (vgpr_wr),
    .wb      (wb),
    .wb_in   (wb_in),
    .done    (done)
);

`default_nettype wire

// ==== dv/lsu_op_manager_tb.sv ====
`default_nettype none

`include "lsu_macros.svh"

module lsu_op_manager_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk = 1'b0;
    logic               rst;
    lsu_pkg::lsu_cmd_t  cmd;
    lsu_pkg::lane_vec_t lane_addr;
    lsu_pkg::lane_vec_t vgpr_rd_data;
    lsu_pkg::wb_rsp_t   wb_in;
    logic               rdy;
    lsu_pkg::vgpr_rd_t  vgpr_rd;
    lsu_pkg::vgpr_wr_t  vgpr_wr;
    lsu_pkg::wb_req_t   wb;
    lsu_pkg::lsu_done_t done;

    int                      seed = 32'h10648d20;
    bit                      rand_ack;
    bit                      in_xfer;
    int                      wait_left;
    int                      cycles;
    int                      done_count;
    int                      tests, checks, errors, test_errors;
    logic [31:0]             mem [logic [31:0]];  // Word addressed
    lsu_pkg::wb_req_t        xfers[$];            // Requests seen when acked
    lsu_pkg::vgpr_wr_t       wr_log[$];
    logic [`LSU_VGPR_AW-1:0] rd_log[$];

    lsu_op_manager UUT (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .lane_addr    (lane_addr),
        .vgpr_rd_data (vgpr_rd_data),
        .wb_in        (wb_in),
        .rdy          (rdy),
        .vgpr_rd      (vgpr_rd),
        .vgpr_wr      (vgpr_wr),
        .wb           (wb),
        .done         (done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the operations did not complete within %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Unwritten words follow the full byte address
    function automatic logic [31:0] model_word(input logic [31:0] adr);
        if (mem.exists(adr >> 2)) return mem[adr >> 2];
        return (adr * 32'h9e3779b1) ^ 32'h5a5aa5a5;
    endfunction

    function automatic lsu_pkg::lane_vec_t row_pattern(input logic [`LSU_VGPR_AW-1:0] addr);
        lsu_pkg::lane_vec_t v;
        for (int l = 0; l < `LSU_LANES; l++) begin
            v[l] = 32'hc0de0000 | (32'(addr) << 4) | 32'(l);
        end
        return v;
    endfunction

    // Wishbone slave memory with 0..3 wait cycles
    always @(posedge clk) begin
        wb_in.ack   <= 1'b0;
        wb_in.dat_r <= '0;  // Read data only alongside ack
        if (rst) begin
            in_xfer = 1'b0;
        end else if (wb.cyc && wb.stb && !wb_in.ack) begin
            if (!in_xfer) begin
                in_xfer   = 1'b1;
                wait_left = rand_ack ? ($random(seed) & 3) : 0;
            end
            if (wait_left == 0) begin
                in_xfer = 1'b0;
                wb_in.ack <= 1'b1;
                xfers.push_back(wb);
                if (wb.we) begin
                    mem[wb.adr >> 2] = wb.dat_w;
                end else begin
                    wb_in.dat_r <= model_word(wb.adr);
                end
            end else begin
                wait_left--;
            end
        end
    end

    // Register file answers one cycle after the read request
    always @(posedge clk) begin
        if (!rst && vgpr_rd.en) begin
            vgpr_rd_data <= row_pattern(vgpr_rd.addr);
            rd_log.push_back(vgpr_rd.addr);
        end else begin
            vgpr_rd_data <= '0;  // Row data only in the cycle after a request
        end
        if (!rst && vgpr_wr.en) wr_log.push_back(vgpr_wr);
        if (!rst && done.valid) done_count++;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic close_test(input string name);
        tests++;
        if (test_errors == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    function automatic lsu_pkg::lsu_cmd_t make_cmd(input bit load, input logic [5:0] wfid,
                                                   input logic [31:0] pc, input logic [1:0] depth,
                                                   input logic [3:0] mask, input logic [9:0] row);
        lsu_pkg::lsu_cmd_t c;
        c           = '0;
        c.valid     = 1'b1;
        c.load      = load;
        c.store     = !load;
        c.wfid      = wfid;
        c.pc        = pc;
        c.depth     = depth;
        c.exec_mask = mask;
        c.dest_row  = load ? row : 10'h3ff;  // Unused row pointer set far away
        c.src_row   = load ? 10'h3ff : row;
        return c;
    endfunction

    function automatic lsu_pkg::lane_vec_t spread(input logic [31:0] base, input logic [31:0] step);
        lsu_pkg::lane_vec_t v;
        for (int l = 0; l < `LSU_LANES; l++) begin
            v[l] = base + 32'(l) * step;
        end
        return v;
    endfunction

    // Command for one cycle and lane addresses in the cycle after acceptance
    task automatic issue_cmd(input lsu_pkg::lsu_cmd_t c, input lsu_pkg::lane_vec_t addrs);
        @(posedge clk);
        cmd <= c;
        @(posedge clk);
        cmd       <= '0;
        lane_addr <= addrs;
    endtask

    task automatic wait_done(output logic [5:0] wfid, output logic [31:0] pc);
        @(posedge clk);
        while (!done.valid) @(posedge clk);
        wfid = done.wfid;
        pc   = done.pc;
    endtask

    task automatic run_op(input lsu_pkg::lsu_cmd_t c, input lsu_pkg::lane_vec_t addrs);
        lsu_pkg::wb_req_t        exp_x[$];
        lsu_pkg::vgpr_wr_t       exp_w[$];
        logic [`LSU_VGPR_AW-1:0] exp_r[$];
        lsu_pkg::wb_req_t        x;
        lsu_pkg::vgpr_wr_t       w;
        lsu_pkg::lane_vec_t      src;
        logic [`LSU_VGPR_AW-1:0] row_a;
        logic [5:0]              wfid;
        logic [31:0]             pc;
        for (int r = 0; r <= int'(c.depth); r++) begin
            row_a  = (c.load ? c.dest_row : c.src_row) + `LSU_VGPR_AW'(r);
            src    = row_pattern(row_a);
            w      = '0;
            w.en   = 1'b1;
            w.addr = row_a;
            w.mask = c.exec_mask;  // Masked lanes stay zero in the row data
            for (int l = 0; l < `LSU_LANES; l++) begin
                if (c.exec_mask[l]) begin
                    x       = '0;
                    x.we    = c.store;
                    x.adr   = addrs[l] + 32'(r) * `LSU_ROW_STRIDE;
                    x.dat_w = src[l];
                    exp_x.push_back(x);
                    if (c.load) w.data[l] = model_word(x.adr);
                end
            end
            if (c.load) exp_w.push_back(w);
            else exp_r.push_back(row_a);
        end
        xfers.delete();
        wr_log.delete();
        rd_log.delete();
        issue_cmd(c, addrs);
        wait_done(wfid, pc);
        check_value("done.wfid", wfid, c.wfid);
        check_value("done.pc", pc, c.pc);
        check_value("bus transfer count", xfers.size(), exp_x.size());
        for (int i = 0; i < exp_x.size() && i < xfers.size(); i++) begin
            check_value("wb.adr", xfers[i].adr, exp_x[i].adr);
            check_value("wb.we", xfers[i].we, exp_x[i].we);
            if (exp_x[i].we) check_value("wb.dat_w", xfers[i].dat_w, exp_x[i].dat_w);
        end
        check_value("vgpr_rd count", rd_log.size(), exp_r.size());
        for (int i = 0; i < exp_r.size() && i < rd_log.size(); i++) begin
            check_value("vgpr_rd.addr", rd_log[i], exp_r[i]);
        end
        check_value("vgpr_wr count", wr_log.size(), exp_w.size());
        for (int i = 0; i < exp_w.size() && i < wr_log.size(); i++) begin
            check_value("vgpr_wr.addr", wr_log[i].addr, exp_w[i].addr);
            check_value("vgpr_wr.mask", wr_log[i].mask, exp_w[i].mask);
            for (int l = 0; l < `LSU_LANES; l++) begin
                check_value("vgpr_wr.data", wr_log[i].data[l], exp_w[i].data[l]);
            end
        end
    endtask

    task automatic reset_and_busy_test();
        logic [5:0]  wfid;
        logic [31:0] pc;
        check_value("rdy", rdy, 1);
        check_value("wb.cyc", wb.cyc, 0);
        check_value("done.valid", done.valid, 0);
        check_value("vgpr_wr.en", vgpr_wr.en, 0);
        done_count = 0;
        issue_cmd(make_cmd(1'b1, 6'h11, 32'h1000, 2'd0, 4'b0101, 10'h020), spread(32'h200, 16));
        repeat (2) @(posedge clk);
        check_value("rdy", rdy, 0);
        cmd <= make_cmd(1'b0, 6'h22, 32'h2000, 2'd1, 4'b1111, 10'h040);  // Arrives while busy
        @(posedge clk);
        cmd <= '0;
        wait_done(wfid, pc);
        repeat (8) @(posedge clk);
        check_value("done.wfid", wfid, 6'h11);
        check_value("done pulse count", done_count, 1);
        check_value("rdy", rdy, 1);
        close_test("reset_and_busy");
    endtask

    task automatic load_full_test();
        run_op(make_cmd(1'b1, 6'h05, 32'h0000_4a10, 2'd0, 4'b1111, 10'h100), spread(32'h1000, 32));
        close_test("load_full_row");
    endtask

    task automatic load_partial_test();
        run_op(make_cmd(1'b1, 6'h2a, 32'h0000_4b20, 2'd1, 4'b1010, 10'h1f0), spread(32'h3000, 64));
        close_test("load_partial_two_rows");
    endtask

    task automatic store_partial_test();
        run_op(make_cmd(1'b0, 6'h33, 32'h0000_4c30, 2'd1, 4'b0110, 10'h2a0), spread(32'h5000, 16));
        close_test("store_partial_two_rows");
    endtask

    task automatic random_ack_test();
        rand_ack = 1'b1;
        run_op(make_cmd(1'b1, 6'h3c, 32'h0000_4d40, 2'd2, 4'b1101, 10'h080), spread(32'h7000, 8));
        run_op(make_cmd(1'b0, 6'h01, 32'h0000_4e50, 2'd3, 4'b1011, 10'h300), spread(32'h7000, 32));
        rand_ack = 1'b0;
        close_test("random_ack_mixed");
    endtask

    initial begin
        rst          = 1'b1;
        cmd          = '0;
        lane_addr    = '0;
        vgpr_rd_data = '0;
        wb_in        = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_and_busy_test();
        load_full_test();
        load_partial_test();
        store_partial_test();
        random_ack_test();
        repeat (4) @(posedge clk);
        errors += UUT.u_assert.assert_errors;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_lane_buffer.sv ====
`default_nettype none

`include "lsu_macros.svh"

module lsu_lane_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  lsu_pkg::lane_vec_t     lane_addr,
    input  logic [`LSU_LANES-1:0]  exec_mask,
    input  lsu_pkg::lane_vec_t     vgpr_rd_data,
    input  logic [`LSU_DATA_W-1:0] rd_data,
    input  logic                   capture,
    input  logic                   restore,
    input  logic                   load_row,
    input  logic                   advance,
    output logic [`LSU_ADDR_W-1:0] cur_addr,
    output logic [`LSU_DATA_W-1:0] cur_data,
    output logic                   lane_active,
    output lsu_pkg::lane_vec_t     row_data,
    output logic [`LSU_LANES-1:0]  row_mask
);

    logic [`LSU_LANES-1:0]  mask_stage;
    logic [`LSU_LANES-1:0]  base_mask;
    logic [`LSU_LANES-1:0]  work_mask;
    lsu_pkg::lane_vec_t     base_addr;
    lsu_pkg::lane_vec_t     work_addr;
    lsu_pkg::lane_vec_t     data_buf;
    logic [`LSU_DATA_W-1:0] fill;

    // Command mask from the accept cycle, taken on capture one cycle later
    always_ff @(posedge clk) begin
        mask_stage <= exec_mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            base_mask <= '0;
            work_mask <= '0;
        end else if (capture) begin
            base_mask <= mask_stage;
            work_mask <= mask_stage;
        end else if (restore) begin
            work_mask <= base_mask;
        end else if (advance) begin
            work_mask <= work_mask >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            base_addr <= lane_addr;
            work_addr <= lane_addr;
        end else if (restore) begin
            work_addr <= base_addr;
        end else if (advance) begin
            work_addr <= work_addr >> `LSU_DATA_W;
        end
    end

    assign fill = lane_active ? rd_data : '0;  // Masked lanes read back as zero

    // Lane 0 is always the current lane; results enter at the top
    always_ff @(posedge clk) begin
        if (load_row) begin
            data_buf <= vgpr_rd_data;
        end else if (advance) begin
            data_buf <= {fill, data_buf[`LSU_LANES-1:1]};
        end
    end

    assign cur_addr    = work_addr[0];
    assign cur_data    = data_buf[0];
    assign lane_active = work_mask[0];
    assign row_data    = data_buf;
    assign row_mask    = base_mask;

endmodule

`default_nettype wire

// ==== hdl/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Lanes in one vector register row
`define LSU_LANES 4

`define LSU_DATA_W 32       // Lane data and bus data width
`define LSU_ADDR_W 32       // Byte address width
`define LSU_WFID_W 6
`define LSU_VGPR_AW 10      // Vector register row address

// Up to four register rows per operation
`define LSU_DEPTH_W 2

`define LSU_ROW_STRIDE 4    // Bytes added to each lane address per row

`endif

// ==== hdl/lsu_op_manager.sv ====
`default_nettype none

`include "lsu_macros.svh"

module lsu_op_manager (
    input  logic               clk,
    input  logic               rst,
    input  lsu_pkg::lsu_cmd_t  cmd,
    input  lsu_pkg::lane_vec_t lane_addr,
    input  lsu_pkg::lane_vec_t vgpr_rd_data,
    input  lsu_pkg::wb_rsp_t   wb_in,
    output logic               rdy,
    output lsu_pkg::vgpr_rd_t  vgpr_rd,
    output lsu_pkg::vgpr_wr_t  vgpr_wr,
    output lsu_pkg::wb_req_t   wb,
    output lsu_pkg::lsu_done_t done
);

    logic                    capture;
    logic                    restore;
    logic                    load_row;
    logic                    advance;
    logic                    start;
    logic                    write;
    logic [`LSU_DEPTH_W-1:0] row;
    logic                    lane_active;
    logic                    lane_finish;
    logic [`LSU_ADDR_W-1:0]  cur_addr;
    logic [`LSU_DATA_W-1:0]  cur_data;
    logic [`LSU_DATA_W-1:0]  rd_data;
    lsu_pkg::lane_vec_t      row_data;
    logic [`LSU_LANES-1:0]   row_mask;
    logic                    wr_en;
    logic [`LSU_VGPR_AW-1:0] wr_addr;

    lsu_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .lane_active (lane_active),
        .lane_finish (lane_finish),
        .rdy         (rdy),
        .capture     (capture),
        .restore     (restore),
        .load_row    (load_row),
        .advance     (advance),
        .start       (start),
        .write       (write),
        .row         (row),
        .vgpr_rd     (vgpr_rd),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .done        (done)
    );

    lsu_lane_buffer u_lane_buffer (
        .clk          (clk),
        .rst          (rst),
        .lane_addr    (lane_addr),
        .exec_mask    (cmd.exec_mask),
        .vgpr_rd_data (vgpr_rd_data),
        .rd_data      (rd_data),
        .capture      (capture),
        .restore      (restore),
        .load_row     (load_row),
        .advance      (advance),
        .cur_addr     (cur_addr),
        .cur_data     (cur_data),
        .lane_active  (lane_active),
        .row_data     (row_data),
        .row_mask     (row_mask)
    );

    lsu_wb_master u_wb_master (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .write     (write),
        .row       (row),
        .lane_addr (cur_addr),
        .lane_data (cur_data),
        .wb_in     (wb_in),
        .wb        (wb),
        .finish    (lane_finish),
        .rd_data   (rd_data)
    );

    // Row write uses the command's execution mask as lane write mask
    assign vgpr_wr.en   = wr_en;
    assign vgpr_wr.addr = wr_addr;
    assign vgpr_wr.data = row_data;
    assign vgpr_wr.mask = row_mask;

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    // One register row, used for lane addresses as well as lane data
    typedef logic [`LSU_LANES-1:0][`LSU_DATA_W-1:0] lane_vec_t;

    typedef struct packed {
        logic                    valid;
        logic                    load;
        logic                    store;
        logic [`LSU_WFID_W-1:0]  wfid;
        logic [`LSU_ADDR_W-1:0]  pc;
        logic [`LSU_DEPTH_W-1:0] depth;     // Rows minus one
        logic [`LSU_LANES-1:0]   exec_mask;
        logic [`LSU_VGPR_AW-1:0] dest_row;  // Load destination
        logic [`LSU_VGPR_AW-1:0] src_row;   // Store source
    } lsu_cmd_t;

    typedef struct packed {
        logic                    en;
        logic [`LSU_VGPR_AW-1:0] addr;
        lane_vec_t               data;
        logic [`LSU_LANES-1:0]   mask;
    } vgpr_wr_t;

    typedef struct packed {
        logic                    en;
        logic [`LSU_VGPR_AW-1:0] addr;
    } vgpr_rd_t;

    // Wishbone classic master side
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LSU_ADDR_W-1:0] adr;
        logic [`LSU_DATA_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`LSU_DATA_W-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic                   valid;
        logic [`LSU_WFID_W-1:0] wfid;
        logic [`LSU_ADDR_W-1:0] pc;
    } lsu_done_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RD,
        ST_RD_REG_WR,
        ST_WR_REG_INIT_RD,
        ST_WR_REG_RD,
        ST_WR,
        ST_WR_REG_INC,
        ST_DONE
    } lsu_state_e;

endpackage

`default_nettype wire

// ==== hdl/lsu_sequencer.sv ====
`default_nettype none

`include "lsu_macros.svh"

module lsu_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  lsu_pkg::lsu_cmd_t       cmd,
    input  logic                    lane_active,
    input  logic                    lane_finish,
    output logic                    rdy,
    output logic                    capture,
    output logic                    restore,
    output logic                    load_row,
    output logic                    advance,
    output logic                    start,
    output logic                    write,
    output logic [`LSU_DEPTH_W-1:0] row,
    output lsu_pkg::vgpr_rd_t       vgpr_rd,
    output logic                    wr_en,
    output logic [`LSU_VGPR_AW-1:0] wr_addr,
    output lsu_pkg::lsu_done_t      done
);

    localparam int LANE_W = $clog2(`LSU_LANES);

    lsu_pkg::lsu_state_e     state, state_next;
    lsu_pkg::lsu_cmd_t       cmd_q;
    logic [LANE_W-1:0]       lane_cnt;
    logic [`LSU_DEPTH_W-1:0] row_cnt;
    logic [`LSU_VGPR_AW-1:0] row_addr;
    logic                    launched;   // Bus transfer of the current lane is open
    logic                    accept;
    logic                    lane_phase;
    logic                    last_lane;
    logic                    last_row;

    assign accept     = (state == lsu_pkg::ST_IDLE) && cmd.valid && (cmd.load || cmd.store);
    assign lane_phase = (state == lsu_pkg::ST_RD) || (state == lsu_pkg::ST_WR);
    assign last_lane  = (lane_cnt == LANE_W'(`LSU_LANES - 1));
    assign last_row   = (row_cnt == cmd_q.depth);

    // Masked lanes step at once, active lanes wait for the bus
    assign start   = lane_phase && lane_active && !launched;
    assign advance = lane_phase && (!lane_active || lane_finish);

    assign capture  = (state == lsu_pkg::ST_ADDR);
    assign load_row = (state == lsu_pkg::ST_WR_REG_RD);
    assign restore  = (state == lsu_pkg::ST_RD_REG_WR) || (state == lsu_pkg::ST_WR_REG_INC);

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::ST_IDLE: if (accept) state_next = lsu_pkg::ST_ADDR;
            lsu_pkg::ST_ADDR: begin
                state_next = cmd_q.load ? lsu_pkg::ST_RD : lsu_pkg::ST_WR_REG_INIT_RD;
            end
            lsu_pkg::ST_RD: if (advance && last_lane) state_next = lsu_pkg::ST_RD_REG_WR;
            lsu_pkg::ST_RD_REG_WR: begin
                state_next = last_row ? lsu_pkg::ST_DONE : lsu_pkg::ST_RD;
            end
            lsu_pkg::ST_WR_REG_INIT_RD: state_next = lsu_pkg::ST_WR_REG_RD;
            lsu_pkg::ST_WR_REG_RD:      state_next = lsu_pkg::ST_WR;
            lsu_pkg::ST_WR: if (advance && last_lane) state_next = lsu_pkg::ST_WR_REG_INC;
            lsu_pkg::ST_WR_REG_INC: begin
                state_next = last_row ? lsu_pkg::ST_DONE : lsu_pkg::ST_WR_REG_INIT_RD;
            end
            lsu_pkg::ST_DONE: state_next = lsu_pkg::ST_IDLE;
            default:          state_next = lsu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= lsu_pkg::ST_IDLE;
            lane_cnt <= '0;
            row_cnt  <= '0;
            launched <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                launched <= 1'b1;
            end else if (lane_finish) begin
                launched <= 1'b0;
            end
            if (accept || restore) begin
                lane_cnt <= '0;
            end else if (advance) begin
                lane_cnt <= lane_cnt + 1'b1;
            end
            if (accept) begin
                row_cnt <= '0;
            end else if (restore) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Command copy and register row pointer
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q    <= cmd;
            row_addr <= cmd.load ? cmd.dest_row : cmd.src_row;
        end else if (restore) begin
            row_addr <= row_addr + 1'b1;
        end
    end

    assign rdy   = (state == lsu_pkg::ST_IDLE);
    assign write = !cmd_q.load;
    assign row   = row_cnt;

    assign vgpr_rd.en   = (state == lsu_pkg::ST_WR_REG_INIT_RD);
    assign vgpr_rd.addr = row_addr;

    assign wr_en   = (state == lsu_pkg::ST_RD_REG_WR);
    assign wr_addr = row_addr;

    assign done.valid = (state == lsu_pkg::ST_DONE);
    assign done.wfid  = cmd_q.wfid;
    assign done.pc    = cmd_q.pc;

endmodule

`default_nettype wire

// ==== hdl/lsu_wb_master.sv ====
`default_nettype none

`include "lsu_macros.svh"

module lsu_wb_master (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    write,
    input  logic [`LSU_DEPTH_W-1:0] row,
    input  logic [`LSU_ADDR_W-1:0]  lane_addr,
    input  logic [`LSU_DATA_W-1:0]  lane_data,
    input  lsu_pkg::wb_rsp_t        wb_in,
    output lsu_pkg::wb_req_t        wb,
    output logic                    finish,
    output logic [`LSU_DATA_W-1:0]  rd_data
);

    logic                   cyc_q;
    logic                   we_q;
    logic [`LSU_ADDR_W-1:0] adr_q;
    logic [`LSU_DATA_W-1:0] dat_q;
    logic [`LSU_ADDR_W-1:0] row_offset;

    assign row_offset = `LSU_ADDR_W'(row) * `LSU_ADDR_W'(`LSU_ROW_STRIDE);

    // Cycle opens on start and closes the cycle after ack
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q  <= 1'b0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (cyc_q && wb_in.ack) begin
                cyc_q  <= 1'b0;
                finish <= 1'b1;
            end else if (start) begin
                cyc_q <= 1'b1;
            end
        end
    end

    // Request held stable until ack
    always_ff @(posedge clk) begin
        if (start && !cyc_q) begin
            we_q  <= write;
            adr_q <= lane_addr + row_offset;
            dat_q <= lane_data;
        end
        if (cyc_q && wb_in.ack) begin
            rd_data <= wb_in.dat_r;
        end
    end

    assign wb.cyc   = cyc_q;
    assign wb.stb   = cyc_q;  // Single transfer per cycle
    assign wb.we    = we_q;
    assign wb.adr   = adr_q;
    assign wb.dat_w = dat_q;

endmodule

`default_nettype wire

// ==== lsu_op_manager.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_sequencer.sv
hdl/lsu_lane_buffer.sv
hdl/lsu_wb_master.sv
hdl/lsu_op_manager.sv
dv/lsu_op_manager_assert.sv
dv/lsu_op_manager_tb.sv
